/* Bender.yml */
package:
  name: arcade_board

sources:
  - hw/board_pkg.sv
  - hw/reset_gen.sv
  - hw/dip_decode.sv
  - hw/input_mapper.sv
  - hw/board_ctrl.sv
  - hw/arcade_board.sv
  - target: simulation
    files:
      - sim/tb_arcade_board.sv

/* hw/arcade_board.sv */
// Single clk_sys domain; keys arrive pre-decoded and board joysticks may be asynchronous
module arcade_board (
    input  logic                            clk_sys,
    input  logic                            rst,
    input  logic                            rst_req,
    input  logic                            downloading,
    // Player inputs
    input  logic [board_pkg::JOY_W-1:0]      board_joystick1,
    input  logic [board_pkg::JOY_W-1:0]      board_joystick2,
    input  logic [board_pkg::GAME_JOY_W-1:0] key_joy1,
    input  logic [board_pkg::GAME_JOY_W-1:0] key_joy2,
    input  logic [1:0]                      key_start,
    input  logic [1:0]                      key_coin,
    input  logic                            key_service,
    // Control keys
    input  logic                            key_reset,
    input  logic                            key_pause,
    input  logic [board_pkg::NUM_FX-1:0]     key_gfx,
    input  logic [board_pkg::NUM_FX-1:0]     key_vgactrl,
    input  logic [board_pkg::STATUS_W-1:0]   status,
    // Game reset
    output logic                            game_rst,
    output logic                            game_rst_n,
    // Game inputs
    output logic [board_pkg::GAME_JOY_W-1:0] game_joystick1,
    output logic [board_pkg::GAME_JOY_W-1:0] game_joystick2,
    output logic [1:0]                      game_coin,
    output logic [1:0]                      game_start,
    output logic                            game_service,
    output logic                            game_pause,
    // DIP and OSD
    output logic                            dip_flip,
    output logic                            dip_pause,
    output logic                            dip_test,
    output logic [1:0]                      dip_fxlevel,
    output logic                            enable_fm,
    output logic                            enable_psg,
    output logic [7:0]                      hdmi_arx,
    output logic [7:0]                      hdmi_ary,
    output logic [board_pkg::NUM_FX-1:0]     gfx_en,
    output logic [board_pkg::NUM_FX-1:0]     vgactrl_en
);

    logic rot_control;
    logic soft_rst;
    logic joy_pause;

    reset_gen i_reset_gen (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .downloading (downloading),
        .rst_req     (rst_req),
        .soft_rst    (soft_rst),
        .dip_flip    (dip_flip),
        .game_rst    (game_rst),
        .game_rst_n  (game_rst_n)
    );

    dip_decode i_dip_decode (
        .clk_sys     (clk_sys),
        .status      (status),
        .game_pause  (game_pause),   // Merged into dip_pause
        .rot_control (rot_control),
        .dip_flip    (dip_flip),
        .dip_pause   (dip_pause),
        .dip_test    (dip_test),
        .dip_fxlevel (dip_fxlevel),
        .enable_fm   (enable_fm),
        .enable_psg  (enable_psg),
        .hdmi_arx    (hdmi_arx),
        .hdmi_ary    (hdmi_ary)
    );

    input_mapper i_input_mapper (
        .clk_sys         (clk_sys),
        .rst             (rst),
        .board_joystick1 (board_joystick1),
        .board_joystick2 (board_joystick2),
        .key_joy1        (key_joy1),
        .key_joy2        (key_joy2),
        .key_start       (key_start),
        .key_coin        (key_coin),
        .key_service     (key_service),
        .rot_control     (rot_control),
        .game_joystick1  (game_joystick1),
        .game_joystick2  (game_joystick2),
        .game_coin       (game_coin),
        .game_start      (game_start),
        .game_service    (game_service),
        .joy_pause       (joy_pause)
    );

    // Pause from the joystick toggles like the pause key
    board_ctrl i_board_ctrl (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .key_reset   (key_reset),
        .key_pause   (key_pause),
        .joy_pause   (joy_pause),
        .key_gfx     (key_gfx),
        .key_vgactrl (key_vgactrl),
        .soft_rst    (soft_rst),
        .game_pause  (game_pause),
        .gfx_en      (gfx_en),
        .vgactrl_en  (vgactrl_en)
    );

endmodule

/* hw/board_ctrl.sv */
// Keys must be clean clk_sys levels; every rising edge counts, there is no debouncing
module board_ctrl (
    input  logic                        clk_sys,
    input  logic                        rst,
    input  logic                        key_reset,
    input  logic                        key_pause,
    input  logic                        joy_pause,
    input  logic [board_pkg::NUM_FX-1:0] key_gfx,
    input  logic [board_pkg::NUM_FX-1:0] key_vgactrl,
    output logic                        soft_rst,
    output logic                        game_pause,
    output logic [board_pkg::NUM_FX-1:0] gfx_en,
    output logic [board_pkg::NUM_FX-1:0] vgactrl_en
);

    import board_pkg::*;

    logic              last_reset;
    logic              last_pause;
    logic              last_joy_pause;
    logic [NUM_FX-1:0] last_gfx;
    logic [NUM_FX-1:0] last_vgactrl;
    logic              pause_edge;
    logic [NUM_FX-1:0] gfx_edge;
    logic [NUM_FX-1:0] vgactrl_edge;

    // Rising edges
    assign pause_edge   = (key_pause & ~last_pause) | (joy_pause & ~last_joy_pause);
    assign gfx_edge     = key_gfx & ~last_gfx;
    assign vgactrl_edge = key_vgactrl & ~last_vgactrl;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_reset     <= 1'b0;
            last_pause     <= 1'b0;
            last_joy_pause <= 1'b0;
            last_gfx       <= '0;
            last_vgactrl   <= '0;
        end else begin
            last_reset     <= key_reset;
            last_pause     <= key_pause;
            last_joy_pause <= joy_pause;
            last_gfx       <= key_gfx;
            last_vgactrl   <= key_vgactrl;
        end
    end

    // Toggles
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            soft_rst   <= 1'b0;
            game_pause <= 1'b0;
            gfx_en     <= '1;  // All layers on
            vgactrl_en <= '0;
        end else begin
            soft_rst   <= key_reset & ~last_reset;  // One cycle per press
            game_pause <= game_pause ^ pause_edge;
            gfx_en     <= gfx_en ^ gfx_edge;
            vgactrl_en <= vgactrl_en ^ vgactrl_edge;
        end
    end

endmodule

/* hw/board_pkg.sv */
// Build-time constants only; button layout and input polarity are fixed here for every instance
package board_pkg;

    // Widths
    localparam int JOY_W      = 16;  // Board joystick word
    localparam int GAME_JOY_W = 10;  // Joystick word seen by the game
    localparam int NUM_FX     = 4;   // Graphics and video-control enables, each
    localparam int STATUS_W   = 32;  // OSD status word

    // Game configuration
    localparam bit THREE_BUTTONS          = 1'b0;
    localparam bit GAME_INPUTS_ACTIVE_LOW = 1'b1;

    // Cycles of game reset after the last trigger, must fit the 8-bit counter
    localparam int GAME_RST_CYCLES = 255;

    // Status word bit positions
    localparam int ST_ROT_BIT   = 2;
    localparam int ST_FLIP_BIT  = 3;
    localparam int ST_PAUSE_BIT = 4;
    localparam int ST_TEST_BIT  = 5;
    localparam int ST_FX_LSB    = 6;   // Two bits
    localparam int ST_NOFM_BIT  = 8;
    localparam int ST_NOPSG_BIT = 9;
    localparam int ST_ARX_LSB   = 16;  // Eight bits
    localparam int ST_ARY_LSB   = 24;  // Eight bits

    // Board joystick word, first field is the MSB
    typedef union packed {
        struct packed {
            logic [5:0] spare;
            logic       pause;
            logic       coin;
            logic       start2;
            logic       start1;
            logic [1:0] button;
            logic       up;
            logic       down;
            logic       left;
            logic       right;
        } two;
        struct packed {
            logic [4:0] spare;
            logic       pause;
            logic       coin;
            logic       start2;
            logic       start1;
            logic [2:0] button;  // One more button pushes the rest up a bit
            logic       up;
            logic       down;
            logic       left;
            logic       right;
        } three;
    } joy_word_u;

endpackage

/* hw/dip_decode.sv */
// Outputs are plain registers with no reset, so they are only valid one cycle after the first clock
module dip_decode (
    input  logic                          clk_sys,
    input  logic [board_pkg::STATUS_W-1:0] status,
    input  logic                          game_pause,
    output logic                          rot_control,
    output logic                          dip_flip,
    output logic                          dip_pause,
    output logic                          dip_test,
    output logic [1:0]                    dip_fxlevel,
    output logic                          enable_fm,
    output logic                          enable_psg,
    output logic [7:0]                    hdmi_arx,
    output logic [7:0]                    hdmi_ary
);

    import board_pkg::*;

    // Core DIPs
    always_ff @(posedge clk_sys) begin
        rot_control <= status[ST_ROT_BIT];
        dip_flip    <= status[ST_FLIP_BIT];
        dip_test    <= ~status[ST_TEST_BIT];                     // Active low
        dip_pause   <= ~(status[ST_PAUSE_BIT] | game_pause);     // Either source pauses
        dip_fxlevel <= status[ST_FX_LSB +: 2];
    end

    // Sound chip enables come in as disable bits
    always_ff @(posedge clk_sys) begin
        enable_fm  <= ~status[ST_NOFM_BIT];
        enable_psg <= ~status[ST_NOPSG_BIT];
    end

    // Aspect ratio for the video output
    always_ff @(posedge clk_sys) begin
        hdmi_arx <= status[ST_ARX_LSB +: 8];
        hdmi_ary <= status[ST_ARY_LSB +: 8];
    end

endmodule

/* hw/input_mapper.sv */
// Board words take a single synchronizer stage only; keys must already be clk_sys levels
module input_mapper (
    input  logic                            clk_sys,
    input  logic                            rst,
    input  logic [board_pkg::JOY_W-1:0]      board_joystick1,
    input  logic [board_pkg::JOY_W-1:0]      board_joystick2,
    input  logic [board_pkg::GAME_JOY_W-1:0] key_joy1,
    input  logic [board_pkg::GAME_JOY_W-1:0] key_joy2,
    input  logic [1:0]                      key_start,
    input  logic [1:0]                      key_coin,
    input  logic                            key_service,
    input  logic                            rot_control,
    output logic [board_pkg::GAME_JOY_W-1:0] game_joystick1,
    output logic [board_pkg::GAME_JOY_W-1:0] game_joystick2,
    output logic [1:0]                      game_coin,
    output logic [1:0]                      game_start,
    output logic                            game_service,
    output logic                            joy_pause
);

    import board_pkg::*;

    joy_word_u  joy1_sync;
    joy_word_u  joy2_sync;
    logic [1:0] joy_coin;
    logic [1:0] joy_start;

    // Swap directions for vertical games
    function automatic logic [GAME_JOY_W-1:0] apply_rotation(
        input logic [GAME_JOY_W-1:0] joy,
        input logic                  rot
    );
        if (rot) begin
            return {joy[GAME_JOY_W-1:4], joy[1], joy[0], joy[2], joy[3]};
        end
        return joy;
    endfunction

    always_ff @(posedge clk_sys) begin
        joy1_sync <= board_joystick1;
        joy2_sync <= board_joystick2;
    end

    // Pick the view matching the button count
    always_comb begin
        if (THREE_BUTTONS) begin
            joy_coin  = {joy2_sync.three.coin, joy1_sync.three.coin};
            joy_start = {joy1_sync.three.start2 | joy2_sync.three.start2,
                         joy1_sync.three.start1 | joy2_sync.three.start1};
            joy_pause = joy1_sync.three.pause | joy2_sync.three.pause;
        end else begin
            joy_coin  = {joy2_sync.two.coin, joy1_sync.two.coin};
            joy_start = {joy1_sync.two.start2 | joy2_sync.two.start2,
                         joy1_sync.two.start1 | joy2_sync.two.start1};
            joy_pause = joy1_sync.two.pause | joy2_sync.two.pause;
        end
    end

    // Output stage, idle is all ones when inputs are active low
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_joystick1 <= {GAME_JOY_W{GAME_INPUTS_ACTIVE_LOW}};
            game_joystick2 <= {GAME_JOY_W{GAME_INPUTS_ACTIVE_LOW}};
            game_coin      <= {2{GAME_INPUTS_ACTIVE_LOW}};
            game_start     <= {2{GAME_INPUTS_ACTIVE_LOW}};
            game_service   <= GAME_INPUTS_ACTIVE_LOW;
        end else begin
            game_joystick1 <= {GAME_JOY_W{GAME_INPUTS_ACTIVE_LOW}} ^
                apply_rotation(joy1_sync[GAME_JOY_W-1:0] | key_joy1, rot_control);
            game_joystick2 <= {GAME_JOY_W{GAME_INPUTS_ACTIVE_LOW}} ^
                apply_rotation(joy2_sync[GAME_JOY_W-1:0] | key_joy2, rot_control);
            game_coin      <= {2{GAME_INPUTS_ACTIVE_LOW}} ^ (joy_coin | key_coin);
            game_start     <= {2{GAME_INPUTS_ACTIVE_LOW}} ^ (joy_start | key_start);
            game_service   <= GAME_INPUTS_ACTIVE_LOW ^ key_service;
        end
    end

endmodule

/* hw/reset_gen.sv */
// Counter is 8 bits wide, so GAME_RST_CYCLES must stay below 256; all triggers are sampled on clk_sys
module reset_gen (
    input  logic clk_sys,
    input  logic rst,
    input  logic downloading,
    input  logic rst_req,
    input  logic soft_rst,
    input  logic dip_flip,
    output logic game_rst,
    output logic game_rst_n
);

    import board_pkg::*;

    logic [7:0] rst_cnt;
    logic       last_dip_flip;
    logic       pre_game_rst_n;
    logic       trigger;

    // Any flip change restarts the game
    assign trigger = rst | downloading | rst_req | soft_rst | (last_dip_flip != dip_flip);

    always_ff @(posedge clk_sys) begin
        last_dip_flip <= dip_flip;
    end

    // Stretch counter
    always_ff @(posedge clk_sys) begin
        if (trigger) begin
            rst_cnt  <= 8'd0;
            game_rst <= 1'b1;
        end else if (rst_cnt != 8'(GAME_RST_CYCLES)) begin
            rst_cnt  <= rst_cnt + 8'd1;
            game_rst <= 1'b1;
        end else begin
            game_rst <= 1'b0;  // Count done, hold the counter
        end
    end

    // Active-low copy, released two cycles late
    always_ff @(posedge clk_sys) begin
        if (rst || game_rst) begin
            pre_game_rst_n <= 1'b0;
            game_rst_n     <= 1'b0;
        end else begin
            pre_game_rst_n <= 1'b1;
            game_rst_n     <= pre_game_rst_n;
        end
    end

endmodule

/* sim/board_stimulus.txt */
// test hold bj1 bj2 kj1 kj2 keys status | exp_joy1 exp_joy2 exp_misc exp_dip exp_stretch
// keys: [1:0] start [3:2] coin 4 service 5 reset 6 pause [11:8] gfx [15:12] vgactrl
// misc: [1:0] coin [3:2] start 4 service 5 pause [11:8] gfx_en [15:12] vgactrl_en
// dip: 0 flip 1 pause_n 2 test_n [4:3] fx 5 fm 6 psg [15:8] arx [23:16] ary
01 03 0000 0000 000 000 0000 00000000  3FF 3FF 0F1F 000066 000
02 04 0009 0002 010 004 0000 00000000  3E6 3F9 0F1F 000066 000
03 04 0140 0080 000 000 0018 00000000  2BF 37F 0F00 000066 000
04 03 0000 0000 000 000 0005 00000000  3FF 3FF 0F1A 000066 000
05 04 0001 0008 002 004 0000 00000004  3F3 3FC 0F1F 000066 000
06 04 0001 0008 002 004 0000 00000000  3FC 3F3 0F1F 000066 000
07 03 0000 0000 000 000 0040 00000000  3FF 3FF 0F3F 000064 000
08 05 0000 0000 000 000 0040 00000000  3FF 3FF 0F3F 000064 000
09 03 0000 0000 000 000 0000 00000000  3FF 3FF 0F3F 000064 000
0A 04 0000 0200 000 000 0000 00000000  3FF 1FF 0F1F 000066 000
0B 03 0000 0000 000 000 0000 00000010  3FF 3FF 0F1F 000064 000
0C 03 0000 0000 000 000 0100 00000000  3FF 3FF 0E1F 000066 000
0D 03 0000 0000 000 000 0400 00000000  3FF 3FF 0A1F 000066 000
0E 03 0000 0000 000 000 2400 00000000  3FF 3FF 2A1F 000066 000
0F 03 0000 0000 000 000 8000 00000000  3FF 3FF AA1F 000066 000
10 03 0000 0000 000 000 0000 00000000  3FF 3FF AA1F 000066 000
11 03 0000 0000 000 000 0020 00000000  3FF 3FF AA1F 000066 100
12 03 0000 0000 000 000 0000 00000000  3FF 3FF AA1F 000066 000
13 03 0000 0000 000 000 0000 00000008  3FF 3FF AA1F 000067 100
14 03 0000 0000 000 000 0000 00000000  3FF 3FF AA1F 000066 100
15 03 0000 0000 000 000 0000 091001A0  3FF 3FF AA1F 091052 000
16 03 0000 0000 000 000 0000 03040240  3FF 3FF AA1F 03042E 000

/* sim/tb_arcade_board.sv */
// Runs from sim/board_stimulus.txt relative to the project root; spare joystick bits are random
module tb_arcade_board;

    import board_pkg::*;

    localparam int NUM_VEC    = 22;
    localparam int NUM_FIELDS = 13;
    localparam int RST_CYCLES = 10;

    logic                  clk_sys;
    logic                  rst;
    logic                  rst_req;
    logic                  downloading;
    logic [JOY_W-1:0]      board_joystick1;
    logic [JOY_W-1:0]      board_joystick2;
    logic [GAME_JOY_W-1:0] key_joy1;
    logic [GAME_JOY_W-1:0] key_joy2;
    logic [1:0]            key_start;
    logic [1:0]            key_coin;
    logic                  key_service;
    logic                  key_reset;
    logic                  key_pause;
    logic [NUM_FX-1:0]     key_gfx;
    logic [NUM_FX-1:0]     key_vgactrl;
    logic [STATUS_W-1:0]   status;
    logic                  game_rst;
    logic                  game_rst_n;
    logic [GAME_JOY_W-1:0] game_joystick1;
    logic [GAME_JOY_W-1:0] game_joystick2;
    logic [1:0]            game_coin;
    logic [1:0]            game_start;
    logic                  game_service;
    logic                  game_pause;
    logic                  dip_flip;
    logic                  dip_pause;
    logic                  dip_test;
    logic [1:0]            dip_fxlevel;
    logic                  enable_fm;
    logic                  enable_psg;
    logic [7:0]            hdmi_arx;
    logic [7:0]            hdmi_ary;
    logic [NUM_FX-1:0]     gfx_en;
    logic [NUM_FX-1:0]     vgactrl_en;

    logic [31:0] vec_mem [0:NUM_VEC*NUM_FIELDS-1];
    integer      seed;
    int          errors;
    int          tests_passed;
    int          cycle_cnt;
    int          cycle_limit;
    int          high_cnt;
    int          low_cnt;
    int          last_stretch;
    int          last_n_delay;
    bit          test_ok;

    arcade_board i_arcade_board (.*);

    always #5 clk_sys = ~clk_sys;

    // Watchdog
    always @(posedge clk_sys) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timed out after %0d cycles, the DUT never reached the expected state",
                     cycle_cnt);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Measures the game reset stretch and the game_rst_n release delay
    always @(negedge clk_sys) begin
        if (game_rst === 1'b1) begin
            high_cnt = high_cnt + 1;
            low_cnt  = 0;
        end else begin
            if (high_cnt != 0) begin
                last_stretch = high_cnt;
                high_cnt     = 0;
            end
            if (game_rst_n === 1'b0) begin
                low_cnt = low_cnt + 1;
            end else if (low_cnt != 0) begin
                last_n_delay = low_cnt;
                low_cnt      = 0;
            end
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors  = errors + 1;
            test_ok = 1'b0;
        end
    endtask

    // Leaves the run one negedge after game_rst_n has risen
    task automatic wait_reset_release();
        while (!(game_rst === 1'b0 && game_rst_n === 1'b1)) begin
            @(negedge clk_sys);
        end
        @(posedge clk_sys);
        @(negedge clk_sys);
    endtask

    task automatic apply_vector(input int v);
        int          base;
        logic [31:0] keys;
        logic [31:0] rnd;
        logic [31:0] got_misc;
        logic [31:0] got_dip;
        base = v * NUM_FIELDS;
        keys = vec_mem[base+6];
        test_ok = 1'b1;
        @(posedge clk_sys);
        #1;
        rnd             = $random(seed);
        board_joystick1 = {rnd[5:0], vec_mem[base+2][9:0]};  // Spare bits must be ignored
        board_joystick2 = {rnd[13:8], vec_mem[base+3][9:0]};
        key_joy1        = vec_mem[base+4][GAME_JOY_W-1:0];
        key_joy2        = vec_mem[base+5][GAME_JOY_W-1:0];
        key_start       = keys[1:0];
        key_coin        = keys[3:2];
        key_service     = keys[4];
        key_reset       = keys[5];
        key_pause       = keys[6];
        key_gfx         = keys[11:8];
        key_vgactrl     = keys[15:12];
        status          = vec_mem[base+7];
        repeat (vec_mem[base+1]) @(posedge clk_sys);
        @(negedge clk_sys);
        got_misc = {16'd0, vgactrl_en, gfx_en, 2'b00, game_pause, game_service,
                    game_start, game_coin};
        got_dip  = {8'd0, hdmi_ary, hdmi_arx, 1'b0, enable_psg, enable_fm, dip_fxlevel,
                    dip_test, dip_pause, dip_flip};
        check_value("game_joystick1", 32'(game_joystick1), vec_mem[base+8]);
        check_value("game_joystick2", 32'(game_joystick2), vec_mem[base+9]);
        check_value("misc outputs", got_misc, vec_mem[base+10]);
        check_value("dip outputs", got_dip, vec_mem[base+11]);
        if (vec_mem[base+12] != 0) begin
            check_value("game_rst during restart", 32'(game_rst), 32'd1);
            last_stretch = 0;  // Only this restart counts
            last_n_delay = 0;
            wait_reset_release();
            check_value("game_rst stretch", 32'(last_stretch), vec_mem[base+12]);
            check_value("game_rst_n delay", 32'(last_n_delay), 32'd2);
        end
        if (test_ok) begin
            tests_passed = tests_passed + 1;
            $display("Test %0d passed", vec_mem[base]);
        end else begin
            $display("Test %0d failed", vec_mem[base]);
        end
    endtask

    initial begin
        clk_sys         = 1'b0;
        rst             = 1'b1;
        rst_req         = 1'b0;
        downloading     = 1'b0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        key_joy1        = '0;
        key_joy2        = '0;
        key_start       = '0;
        key_coin        = '0;
        key_service     = 1'b0;
        key_reset       = 1'b0;
        key_pause       = 1'b0;
        key_gfx         = '0;
        key_vgactrl     = '0;
        status          = '0;
        seed            = 32'h64ef015a;
        errors          = 0;
        tests_passed    = 0;
        cycle_cnt       = 0;
        high_cnt        = 0;
        low_cnt         = 0;
        last_stretch    = 0;
        last_n_delay    = 0;
        $readmemh("sim/board_stimulus.txt", vec_mem);

        // Budget from the holds plus every reset stretch
        cycle_limit = 100 + RST_CYCLES + GAME_RST_CYCLES + 4;
        for (int v = 0; v < NUM_VEC; v++) begin
            cycle_limit = cycle_limit + vec_mem[v*NUM_FIELDS+1] + 2;
            if (vec_mem[v*NUM_FIELDS+12] != 0) begin
                cycle_limit = cycle_limit + vec_mem[v*NUM_FIELDS+12] + 4;
            end
        end

        repeat (RST_CYCLES) @(posedge clk_sys);
        #1;
        rst     = 1'b0;
        test_ok = 1'b1;
        wait_reset_release();
        check_value("power-on stretch", 32'(last_stretch), 32'(RST_CYCLES + GAME_RST_CYCLES));
        check_value("game_rst_n delay", 32'(last_n_delay), 32'd2);
        check_value("game_pause", 32'(game_pause), 32'd0);
        check_value("gfx_en", 32'(gfx_en), 32'hF);
        check_value("vgactrl_en", 32'(vgactrl_en), 32'h0);
        check_value("game_joystick1", 32'(game_joystick1), 32'h3FF);
        if (test_ok) begin
            tests_passed = tests_passed + 1;
            $display("Test 0 passed");
        end else begin
            $display("Test 0 failed");
        end

        for (int v = 0; v < NUM_VEC; v++) begin
            apply_vector(v);
        end

        $display("%0d tests run, %0d passed, %0d checks failed",
                 NUM_VEC + 1, tests_passed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
hw/board_pkg.sv
hw/reset_gen.sv
hw/dip_decode.sv
hw/input_mapper.sv
hw/board_ctrl.sv
hw/arcade_board.sv
sim/tb_arcade_board.sv
